//--- build.f
+incdir+test
hdl/io_pkg.sv
hdl/io_decoder.sv
hdl/io_indicators.sv
hdl/io_timer.sv
hdl/io_intcon.sv
hdl/io_subsystem.sv
test/io_subsystem_tb.sv

//--- hdl/io_decoder.sv
`timescale 1ns/1ps

module io_decoder
(
	input logic clk_sys,
	input logic rst,
	input io_pkg::io_req_t req,
	output io_pkg::io_sel_t sel,
	input logic [io_pkg::io_byte_w-1:0] hex_rd,
	input logic [io_pkg::io_byte_w-1:0] timer_rd,
	input logic [io_pkg::io_byte_w-1:0] intcon_rd,
	output logic [io_pkg::io_data_w-1:0] rdata,
	output logic rd_valid
);

	import io_pkg::*;

	logic [io_byte_w-1:0] rd_byte;

	// ############################
	// address decode
	// ############################

	// full compare for the one-word indicators
	assign sel.hex = (req.addr == hex_base);
	assign sel.led = (req.addr == led_base);
	// timer owns the low two address bits
	assign sel.timer = (req.addr[io_addr_w-1:2] == timer_base[io_addr_w-1:2]);
	// intcon owns the low address bit
	assign sel.intcon = (req.addr[io_addr_w-1:1] == intcon_base[io_addr_w-1:1]);

	// ############################
	// read mux
	// ############################

	// device bytes arrive in the request cycle
	always_comb
	begin
		rd_byte = '0;
		if (sel.hex)
			rd_byte = hex_rd;
		if (sel.timer)
			rd_byte = timer_rd;
		if (sel.intcon)
			rd_byte = intcon_rd;
		// led and unmapped stay zero
	end

	// read word lands one cycle after ren
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			rdata <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= req.ren;
			// high byte always zero for 8-bit devices
			if (req.ren)
				rdata <= {{(io_data_w-io_byte_w){1'b0}}, rd_byte};
		end
	end

	// map regions must never overlap
	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0(sel));

endmodule

//--- hdl/io_indicators.sv
`timescale 1ns/1ps

module io_indicators
(
	input logic clk_sys,
	input logic rst,
	input io_pkg::io_req_t req,
	input io_pkg::io_sel_t sel,
	output logic [io_pkg::io_byte_w-1:0] ledr,
	output logic [io_pkg::io_byte_w-1:0] ledg,
	output io_pkg::seg7_t hex0_d,
	output io_pkg::seg7_t hex1_d,
	output io_pkg::seg7_t hex2_d,
	output io_pkg::seg7_t hex3_d
);

	import io_pkg::*;

	logic [io_data_w-1:0] hex_word;
	logic [io_data_w-1:0] led_word;

	// nibble to active-low glyph
	function automatic seg7_t seg7_enc(input logic [3:0] nib);
		seg7_t seg;
		case (nib)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'hA: seg = 7'h08;
			4'hB: seg = 7'h03;
			4'hC: seg = 7'h46;
			4'hD: seg = 7'h21;
			4'hE: seg = 7'h06;
			default: seg = 7'h0E;
		endcase
		return seg;
	endfunction

	// ############################
	// indicator words
	// ############################

	// byte lanes follow hen and len
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			hex_word <= '0;
			led_word <= '0;
		end
		else if (req.wren)
		begin
			if (sel.hex && req.hen)
				hex_word[15:8] <= req.wdata[15:8];
			if (sel.hex && req.len)
				hex_word[7:0] <= req.wdata[7:0];
			if (sel.led && req.hen)
				led_word[15:8] <= req.wdata[15:8];
			if (sel.led && req.len)
				led_word[7:0] <= req.wdata[7:0];
		end
	end

	// red on the high byte, green on the low
	assign ledr = led_word[15:8];
	assign ledg = led_word[7:0];

	// hex0 is the lowest nibble
	assign hex0_d = seg7_enc(hex_word[3:0]);
	assign hex1_d = seg7_enc(hex_word[7:4]);
	assign hex2_d = seg7_enc(hex_word[11:8]);
	assign hex3_d = seg7_enc(hex_word[15:12]);

endmodule

//--- hdl/io_intcon.sv
`timescale 1ns/1ps

module io_intcon
(
	input logic clk_sys,
	input logic rst,
	input io_pkg::io_req_t req,
	input logic sel_intcon,
	input logic button,
	input logic timer_int,
	input logic [5:0] ext_irq,
	output logic [io_pkg::io_byte_w-1:0] rd_byte,
	output logic int_rq,
	output logic [2:0] int_addr
);

	import io_pkg::*;

	logic btn_meta;
	logic btn_sync;
	logic [irq_n-1:0] irq_in;
	logic [irq_n-1:0] irq_prev;
	logic [irq_n-1:0] rise;
	logic [irq_n-1:0] pending;
	logic [irq_n-1:0] mask;
	logic [irq_n-1:0] active;
	logic wr_mask;
	logic wr_pend;

	// ############################
	// input capture
	// ############################

	// button is asynchronous, two flops, active high
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
			irq_prev <= '0;
		end
		else
		begin
			btn_meta <= button;
			btn_sync <= btn_meta;
			irq_prev <= irq_in;
		end
	end

	// ext_irq 0-4 on slots 1-5, ext_irq 5 on slot 7
	always_comb
	begin
		irq_in = {ext_irq[5], 1'b0, ext_irq[4:0], 1'b0};
		irq_in[irq_button] = btn_sync;
		irq_in[irq_timer] = timer_int;
	end

	assign rise = irq_in & ~irq_prev;

	// ############################
	// registers
	// ############################

	assign wr_mask = sel_intcon && req.wren && req.len && (req.addr[0] == int_mask_ofs);
	assign wr_pend = sel_intcon && req.wren && req.len && (req.addr[0] == int_pend_ofs);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			pending <= '0;
			mask <= '0;
		end
		else
		begin
			if (wr_mask)
				mask <= req.wdata[irq_n-1:0];
			// write one clears, a fresh edge still wins
			if (wr_pend)
				pending <= (pending & ~req.wdata[irq_n-1:0]) | rise;
			else
				pending <= pending | rise;
		end
	end

	assign rd_byte = (req.addr[0] == int_pend_ofs) ? pending : mask;

	// ############################
	// request and priority
	// ############################

	assign active = pending & mask;
	assign int_rq = |active;

	// lowest index wins, scan from the top down
	always_comb
	begin
		int_addr = '0;
		for (int i = irq_n - 1; i >= 0; i--)
			if (active[i])
				int_addr = 3'(i);
	end

	// vector must point at a live, enabled source
	a_vec_valid: assert property (@(posedge clk_sys) disable iff (rst)
		int_rq |-> (pending[int_addr] && mask[int_addr]));

endmodule

//--- hdl/io_pkg.sv
package io_pkg;

	// ############################
	// widths
	// ############################

	localparam int io_addr_w = 16;
	localparam int io_data_w = 16;
	localparam int io_byte_w = 8;
	localparam int timer_w = 24;
	localparam int irq_n = 8;

	// ############################
	// io address map
	// ############################

	// single-address indicator words, write only
	localparam logic [io_addr_w-1:0] hex_base = 16'hFFFC;
	localparam logic [io_addr_w-1:0] led_base = 16'hFFFD;
	// timer spans 0xFFF0 to 0xFFF3
	localparam logic [io_addr_w-1:0] timer_base = 16'hFFF0;
	// intcon spans 0xFFEE to 0xFFEF
	localparam logic [io_addr_w-1:0] intcon_base = 16'hFFEE;

	// register offsets inside a device
	localparam logic [1:0] tmr_status_ofs = 2'd3;
	localparam logic int_mask_ofs = 1'b0;
	localparam logic int_pend_ofs = 1'b1;

	// interrupt input slots
	localparam int irq_button = 0;
	localparam int irq_timer = 6;

	// ############################
	// bus types
	// ############################

	// one request from the master, all strobes single cycle
	typedef struct packed {
		logic [io_addr_w-1:0] addr;
		logic [io_data_w-1:0] wdata;
		logic wren;
		logic ren;
		logic hen;
		logic len;
	} io_req_t;

	// one-hot device selects
	typedef struct packed {
		logic hex;
		logic led;
		logic timer;
		logic intcon;
	} io_sel_t;

	// active low, bit 6 is segment g, bit 0 is segment a
	typedef logic [6:0] seg7_t;

endpackage

//--- hdl/io_subsystem.sv
`timescale 1ns/1ps

module io_subsystem
(
	input logic clk_sys,
	input logic rst,
	input io_pkg::io_req_t req,
	input logic button,
	input logic [5:0] ext_irq,
	output logic [io_pkg::io_data_w-1:0] rdata,
	output logic rd_valid,
	output logic int_rq,
	output logic [2:0] int_addr,
	output logic [io_pkg::io_byte_w-1:0] ledr,
	output logic [io_pkg::io_byte_w-1:0] ledg,
	output io_pkg::seg7_t hex0_d,
	output io_pkg::seg7_t hex1_d,
	output io_pkg::seg7_t hex2_d,
	output io_pkg::seg7_t hex3_d
);

	import io_pkg::*;

	io_sel_t sel;
	logic [io_byte_w-1:0] timer_rd;
	logic [io_byte_w-1:0] intcon_rd;
	logic timer_int;

	// ############################
	// decode and read path
	// ############################

	// hex registers are write only, so their read byte is zero
	io_decoder u_decoder (.clk_sys(clk_sys), .rst(rst), .req(req), .sel(sel),
		.hex_rd(8'h00), .timer_rd(timer_rd), .intcon_rd(intcon_rd),
		.rdata(rdata), .rd_valid(rd_valid));

	// ############################
	// devices
	// ############################

	io_indicators u_indicators (.clk_sys(clk_sys), .rst(rst), .req(req), .sel(sel),
		.ledr(ledr), .ledg(ledg), .hex0_d(hex0_d), .hex1_d(hex1_d),
		.hex2_d(hex2_d), .hex3_d(hex3_d));

	io_timer u_timer (.clk_sys(clk_sys), .rst(rst), .req(req), .sel_timer(sel.timer),
		.rd_byte(timer_rd), .timer_int(timer_int));

	// timer zero pulse feeds slot 6
	io_intcon u_intcon (.clk_sys(clk_sys), .rst(rst), .req(req), .sel_intcon(sel.intcon),
		.button(button), .timer_int(timer_int), .ext_irq(ext_irq),
		.rd_byte(intcon_rd), .int_rq(int_rq), .int_addr(int_addr));

endmodule

//--- hdl/io_timer.sv
`timescale 1ns/1ps

module io_timer
(
	input logic clk_sys,
	input logic rst,
	input io_pkg::io_req_t req,
	input logic sel_timer,
	output logic [io_pkg::io_byte_w-1:0] rd_byte,
	output logic timer_int
);

	import io_pkg::*;

	logic [timer_w-1:0] count;
	logic [io_byte_w-1:0] status;
	logic load;
	logic running;

	// byte load on offsets 0 to 2, status is read only
	assign load = sel_timer && req.wren && req.len && (req.addr[1:0] != tmr_status_ofs);
	assign running = (count != '0);

	// ############################
	// counter
	// ############################

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			count <= '0;
			timer_int <= 1'b0;
		end
		else
		begin
			// pulse on the 1 to 0 step only
			timer_int <= !load && (count == timer_w'(1));
			if (load)
			begin
				// written byte replaces its lane, others hold
				case (req.addr[1:0])
					2'd0: count[7:0] <= req.wdata[7:0];
					2'd1: count[15:8] <= req.wdata[7:0];
					default: count[23:16] <= req.wdata[7:0];
				endcase
			end
			else if (running)
				count <= count - 1'b1;
		end
	end

	// ############################
	// read side
	// ############################

	// per-byte nonzero flags plus whole counter
	assign status = {4'b0000, running, |count[23:16], |count[15:8], |count[7:0]};

	always_comb
	begin
		case (req.addr[1:0])
			2'd0: rd_byte = count[7:0];
			2'd1: rd_byte = count[15:8];
			2'd2: rd_byte = count[23:16];
			default: rd_byte = status;
		endcase
	end

	// idle counter stays idle until reloaded
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (rst)
		(count == '0 && !load) |=> (count == '0));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the io subsystem testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module io_subsystem_tb -o io_sim

./obj_dir/io_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- test/io_tb_tasks.svh
// ##############################
// bus drivers
// ##############################

// present a write for one cycle from the next rising edge
task issue_write(input logic [15:0] addr, input logic [15:0] data, input logic hen,
	input logic len);
	io_req_t r;
	r = '0;
	r.addr = addr;
	r.wdata = data;
	r.wren = 1'b1;
	r.hen = hen;
	r.len = len;
	@(posedge clk_sys);
	req <= r;
endtask

// present a read for one cycle
task issue_read(input logic [15:0] addr);
	io_req_t r;
	r = '0;
	r.addr = addr;
	r.ren = 1'b1;
	@(posedge clk_sys);
	req <= r;
endtask

// bus back to idle at the next edge
task bus_idle();
	@(posedge clk_sys);
	req <= '0;
endtask

// read word is due one cycle after the request
task collect_read(output logic [15:0] data);
	@(negedge clk_sys);
	if (rd_valid !== 1'b1)
		fail_stop("read data valid did not arrive one cycle after the read request");
	data = rdata;
endtask

task bus_write(input logic [15:0] addr, input logic [15:0] data, input logic hen,
	input logic len);
	issue_write(addr, data, hen, len);
	bus_idle();
endtask

task bus_read(input logic [15:0] addr, output logic [15:0] data);
	issue_read(addr);
	bus_idle();
	collect_read(data);
endtask

// ##############################
// reporting
// ##############################

task fail_stop(input string msg);
	$display("%s", msg);
	$display("Test failures found");
	$fatal(1, "run stopped");
endtask

task check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp)
	begin
		$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		$display("Test failures found");
		$fatal(1, "value mismatch");
	end
endtask

//--- test/io_subsystem_tb.sv
`timescale 1ns/1ps

module io_subsystem_tb;

	import io_pkg::*;

	localparam int clk_half = 20;
	localparam int rst_cycles = 5;
	// tests take well under 1000 cycles
	// limit is about twice that
	localparam int timeout_cycles = 2000;
	// register addresses built from the map
	localparam logic [15:0] tmr_stat_addr = {timer_base[15:2], tmr_status_ofs};
	localparam logic [15:0] int_mask_addr = {intcon_base[15:1], int_mask_ofs};
	localparam logic [15:0] int_pend_addr = {intcon_base[15:1], int_pend_ofs};
	// active-low glyphs 0 to F
	// bit 7 is not wired on a digit
	localparam logic [7:0] glyph [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92,
		8'h82, 8'hF8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

	logic clk_sys;
	logic rst;
	io_req_t req;
	logic button;
	logic [5:0] ext_irq;
	logic [15:0] rdata;
	logic rd_valid;
	logic int_rq;
	logic [2:0] int_addr;
	logic [7:0] ledr;
	logic [7:0] ledg;
	seg7_t hex0_d;
	seg7_t hex1_d;
	seg7_t hex2_d;
	seg7_t hex3_d;
	int cycle_cnt = 0;
	integer seed;

	io_subsystem UUT (.clk_sys(clk_sys), .rst(rst), .req(req), .button(button),
		.ext_irq(ext_irq), .rdata(rdata), .rd_valid(rd_valid), .int_rq(int_rq),
		.int_addr(int_addr), .ledr(ledr), .ledg(ledg), .hex0_d(hex0_d),
		.hex1_d(hex1_d), .hex2_d(hex2_d), .hex3_d(hex3_d));

	`include "io_tb_tasks.svh"

	// ##############################
	// clock and watchdog
	// ##############################

	initial
	begin
		clk_sys = 1'b0;
		forever #clk_half clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles)
			fail_stop("simulation timed out before the tests finished");
	end

	// all four digits against the glyph table
	task check_hex(input logic [15:0] word);
		check_eq("hex0_d", hex0_d, glyph[word[3:0]][6:0]);
		check_eq("hex1_d", hex1_d, glyph[word[7:4]][6:0]);
		check_eq("hex2_d", hex2_d, glyph[word[11:8]][6:0]);
		check_eq("hex3_d", hex3_d, glyph[word[15:12]][6:0]);
	endtask

	// one-cycle pulse on an external request pin
	task pulse_irq(input int idx);
		@(posedge clk_sys);
		ext_irq[idx] <= 1'b1;
		@(posedge clk_sys);
		ext_irq[idx] <= 1'b0;
	endtask

	// request with a given vector
	// gives up after 8 cycles
	task wait_vector(input logic [2:0] vec);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(int_rq && int_addr == vec) && n < 8)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (n == 8)
			fail_stop($sformatf("no interrupt request with vector %0d", vec));
		check_eq("int_addr", int_addr, vec);
	endtask

	// ##############################
	// directed tests
	// ##############################

	task test_reset();
		check_eq("ledr", ledr, 0);
		check_eq("ledg", ledg, 0);
		check_eq("int_rq", int_rq, 0);
		check_eq("rd_valid", rd_valid, 0);
		check_hex(16'h0000);
	endtask

	task test_indicators();
		logic [15:0] led_val;
		logic [15:0] led_new;
		led_val = $random(seed);
		led_new = ~led_val;
		bus_write(hex_base, 16'h3A5F, 1'b1, 1'b1);
		@(negedge clk_sys);
		check_hex(16'h3A5F);
		bus_write(led_base, led_val, 1'b1, 1'b1);
		@(negedge clk_sys);
		check_eq("ledr", ledr, led_val[15:8]);
		check_eq("ledg", ledg, led_val[7:0]);
		// upper lane only, green holds
		bus_write(led_base, led_new, 1'b1, 1'b0);
		@(negedge clk_sys);
		check_eq("ledr", ledr, led_new[15:8]);
		check_eq("ledg", ledg, led_val[7:0]);
	endtask

	task test_read_path();
		logic [15:0] data;
		issue_read(tmr_stat_addr);
		@(negedge clk_sys);
		check_eq("rd_valid", rd_valid, 0);
		bus_idle();
		collect_read(data);
		check_eq("timer status", data, 16'h0000);
		// pulse lasts a single cycle
		@(negedge clk_sys);
		check_eq("rd_valid", rd_valid, 0);
		// nonzero read word first so stale data would show
		bus_write(int_mask_addr, 16'h003C, 1'b0, 1'b1);
		bus_read(int_mask_addr, data);
		check_eq("int mask", data, 16'h003C);
		bus_read(16'h1234, data);
		check_eq("unmapped read", data, 16'h0000);
		bus_read(int_mask_addr, data);
		check_eq("int mask", data, 16'h003C);
		bus_read(hex_base, data);
		check_eq("hex read", data, 16'h0000);
	endtask

	task test_timer();
		logic [15:0] data;
		issue_write(timer_base, 16'd50, 1'b0, 1'b1);
		issue_read(tmr_stat_addr);
		bus_idle();
		collect_read(data);
		check_eq("timer status", data, 16'h0009);
		// 50 steps to zero
		repeat (60) @(posedge clk_sys);
		bus_read(tmr_stat_addr, data);
		check_eq("timer status", data, 16'h0000);
		bus_read(int_pend_addr, data);
		check_eq("int pending", data, 16'h0040);
	endtask

	task test_interrupts();
		logic [15:0] data;
		bus_write(int_mask_addr, 16'h0006, 1'b0, 1'b1);
		pulse_irq(0);
		wait_vector(3'd1);
		// write one clears slot 1
		bus_write(int_pend_addr, 16'h0002, 1'b0, 1'b1);
		@(negedge clk_sys);
		check_eq("int_rq", int_rq, 0);
		bus_write(int_mask_addr, 16'h0003, 1'b0, 1'b1);
		pulse_irq(0);
		wait_vector(3'd1);
		@(posedge clk_sys);
		button <= 1'b1;
		// button slot outranks slot 1
		wait_vector(3'd0);
		bus_read(int_pend_addr, data);
		check_eq("int pending", data, 16'h0043);
		@(posedge clk_sys);
		button <= 1'b0;
	endtask

	task test_back_to_back();
		logic [15:0] data;
		issue_write(int_mask_addr, 16'h00A5, 1'b0, 1'b1);
		issue_read(int_mask_addr);
		bus_idle();
		collect_read(data);
		check_eq("int mask", data, 16'h00A5);
	endtask

	// ##############################
	// main sequence
	// ##############################

	initial
	begin
		rst = 1'b1;
		req = '0;
		button = 1'b0;
		ext_irq = '0;
		seed = 32'h9441fb2d;
		repeat (rst_cycles) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		test_reset();
		test_indicators();
		test_read_path();
		test_timer();
		test_interrupts();
		test_back_to_back();
		$display("All tests passed!");
		$finish;
	end

endmodule
